/* files.f */
hw/panel_pkg.sv
hw/i2c_read_master.sv
hw/i2c_arbiter.sv
hw/adc_poller.sv
hw/uart_link.sv
hw/seg_display.sv
hw/sensor_panel_top.sv
tb/i2c_adc_model.sv
tb/panel_checker.sv
tb/tb_sensor_panel.sv

/* hw/adc_poller.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// periodic read of ADC register 0
// keeps the last acknowledged value for the display
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module adc_poller #(
	parameter int POLL_CYCLES = 5_000_000
) (
	input  logic                sys_clk,
	input  logic                sys_rst_n,
	output logic                req,
	output panel_pkg::i2c_req_t cmd,
	input  logic                done,
	input  panel_pkg::i2c_rsp_t rsp,
	output logic [7:0]          reading
);

	localparam int CNT_W = (POLL_CYCLES > 1) ? $clog2(POLL_CYCLES) : 1;

	logic [CNT_W-1:0] timer;

	assign cmd = '{reg_addr: 8'h00};

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			timer   <= CNT_W'(POLL_CYCLES - 1);
			req     <= 1'b0;
			reading <= '0;
		end else if (done) begin
			req   <= 1'b0;
			timer <= CNT_W'(POLL_CYCLES - 1);
			// a nack keeps the old reading
			if (!rsp.nack) begin
				reading <= rsp.data;
			end
		end else if (!req) begin
			if (timer == '0) begin
				req <= 1'b1;
			end else begin
				timer <= timer - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* hw/i2c_arbiter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shares the I2C master between poller and UART link
// poller wins ties, owner holds until master done
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module i2c_arbiter (
	input  logic                sys_clk,
	input  logic                sys_rst_n,
	input  logic                poll_req,
	input  panel_pkg::i2c_req_t poll_cmd,
	output logic                poll_done,
	input  logic                uart_req,
	input  panel_pkg::i2c_req_t uart_cmd,
	output logic                uart_done,
	input  panel_pkg::i2c_rsp_t rsp_in,
	output panel_pkg::i2c_rsp_t rsp,
	output logic                mst_start,
	output panel_pkg::i2c_req_t mst_cmd,
	input  logic                mst_done
);

	panel_pkg::bus_owner_e owner;

	// done goes to the owner only
	assign poll_done = mst_done && (owner == panel_pkg::OWN_POLL);
	assign uart_done = mst_done && (owner == panel_pkg::OWN_UART);
	assign rsp       = rsp_in;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			owner     <= panel_pkg::OWN_NONE;
			mst_start <= 1'b0;
			mst_cmd   <= '0;
		end else begin
			mst_start <= 1'b0;
			if (owner == panel_pkg::OWN_NONE) begin
				if (poll_req) begin
					owner     <= panel_pkg::OWN_POLL;
					mst_cmd   <= poll_cmd;
					mst_start <= 1'b1;
				end else if (uart_req) begin
					owner     <= panel_pkg::OWN_UART;
					mst_cmd   <= uart_cmd;
					mst_start <= 1'b1;
				end
			end else if (mst_done) begin
				owner <= panel_pkg::OWN_NONE;
			end
		end
	end

endmodule

`default_nettype wire

/* hw/i2c_read_master.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// I2C master for one random-address byte read
// start pulse launches a read, done pulses with rsp
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module i2c_read_master #(
	parameter int         CLK_HZ    = 50_000_000,
	parameter int         I2C_HZ    = 100_000,
	parameter logic [6:0] DEVICE_ID = 7'h54
) (
	input  logic                sys_clk,
	input  logic                sys_rst_n,
	input  logic                start,
	input  panel_pkg::i2c_req_t req,
	output logic                done,
	output panel_pkg::i2c_rsp_t rsp,
	output logic                scl,
	inout  wire                 sda
);

	localparam int QUARTER = (CLK_HZ / (I2C_HZ * 4) > 0) ? CLK_HZ / (I2C_HZ * 4) : 1;
	localparam int DIV_W   = $clog2(QUARTER + 1);

	panel_pkg::i2c_state_e state;
	logic [DIV_W-1:0]      div_cnt;
	logic [1:0]            phase;
	logic [3:0]            bit_cnt;
	logic [7:0]            reg_addr;
	logic [7:0]            shift;
	logic                  nack;
	logic                  tick;
	logic                  slot_end;
	logic                  scl_nxt;
	logic                  sda_nxt;
	logic                  sda_q;
	logic                  sda_in;

	// open drain, pull-up is external
	assign sda      = sda_q ? 1'bz : 1'b0;
	assign sda_in   = sda;
	assign tick     = (div_cnt == DIV_W'(QUARTER - 1));
	assign slot_end = tick && (phase == 2'd3);

	// bus levels per quarter of the current bit slot
	always_comb begin
		scl_nxt = 1'b1;
		sda_nxt = 1'b1;
		case (state)
			panel_pkg::ST_START: begin
				scl_nxt = (phase != 2'd3);
				sda_nxt = (phase < 2'd2);
			end
			panel_pkg::ST_RESTART: begin
				scl_nxt = (phase == 2'd1) || (phase == 2'd2);
				sda_nxt = (phase < 2'd2);
			end
			panel_pkg::ST_STOP: begin
				scl_nxt = (phase != 2'd0);
				sda_nxt = (phase >= 2'd2);
			end
			panel_pkg::ST_ADDR_WR, panel_pkg::ST_REG, panel_pkg::ST_ADDR_RD: begin
				scl_nxt = (phase == 2'd1) || (phase == 2'd2);
				// released during the ack slot
				sda_nxt = bit_cnt[3] | shift[7];
			end
			panel_pkg::ST_DATA_RD, panel_pkg::ST_MNACK: begin
				scl_nxt = (phase == 2'd1) || (phase == 2'd2);
			end
			default: ;
		endcase
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= panel_pkg::ST_IDLE;
			div_cnt  <= '0;
			phase    <= '0;
			bit_cnt  <= '0;
			reg_addr <= '0;
			shift    <= '0;
			nack     <= 1'b0;
			done     <= 1'b0;
			rsp      <= '0;
			scl      <= 1'b1;
			sda_q    <= 1'b1;
		end else begin
			done  <= 1'b0;
			scl   <= scl_nxt;
			sda_q <= sda_nxt;
			if (state == panel_pkg::ST_IDLE) begin
				div_cnt <= '0;
				phase   <= '0;
			end else if (tick) begin
				div_cnt <= '0;
				phase   <= phase + 2'd1;
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
			case (state)
				panel_pkg::ST_IDLE: begin
					if (start) begin
						reg_addr <= req.reg_addr;
						nack     <= 1'b0;
						state    <= panel_pkg::ST_START;
					end
				end
				panel_pkg::ST_START, panel_pkg::ST_RESTART: begin
					if (slot_end) begin
						bit_cnt <= '0;
						shift   <= {DEVICE_ID, state == panel_pkg::ST_RESTART};
						state   <= (state == panel_pkg::ST_START) ? panel_pkg::ST_ADDR_WR
							: panel_pkg::ST_ADDR_RD;
					end
				end
				panel_pkg::ST_ADDR_WR, panel_pkg::ST_REG, panel_pkg::ST_ADDR_RD: begin
					// ack sampled while scl is high
					if (tick && phase == 2'd2 && bit_cnt[3]) begin
						nack <= sda_in;
					end
					if (slot_end) begin
						if (!bit_cnt[3]) begin
							shift   <= {shift[6:0], 1'b0};
							bit_cnt <= bit_cnt + 4'd1;
						end else if (nack) begin
							state <= panel_pkg::ST_STOP;
						end else begin
							bit_cnt <= '0;
							shift   <= reg_addr;
							if (state == panel_pkg::ST_ADDR_WR) begin
								state <= panel_pkg::ST_REG;
							end else if (state == panel_pkg::ST_REG) begin
								state <= panel_pkg::ST_RESTART;
							end else begin
								state <= panel_pkg::ST_DATA_RD;
							end
						end
					end
				end
				panel_pkg::ST_DATA_RD: begin
					if (tick && phase == 2'd2) begin
						shift <= {shift[6:0], sda_in};
					end
					if (slot_end) begin
						bit_cnt <= bit_cnt + 4'd1;
						if (bit_cnt == 4'd7) begin
							state <= panel_pkg::ST_MNACK;
						end
					end
				end
				panel_pkg::ST_MNACK: begin
					if (slot_end) begin
						state <= panel_pkg::ST_STOP;
					end
				end
				panel_pkg::ST_STOP: begin
					if (slot_end) begin
						rsp   <= '{data: shift, nack: nack};
						done  <= 1'b1;
						state <= panel_pkg::ST_IDLE;
					end
				end
				default: state <= panel_pkg::ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hw/panel_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types and constants of the sensor panel
// referenced by scoped names from the RTL modules
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package panel_pkg;

	// one register read request
	typedef struct packed {
		logic [7:0] reg_addr;
	} i2c_req_t;

	// read result, nack set when the device did not acknowledge
	typedef struct packed {
		logic [7:0] data;
		logic       nack;
	} i2c_rsp_t;

	typedef enum logic [3:0] {
		ST_IDLE,
		ST_START,
		ST_ADDR_WR,
		ST_REG,
		ST_RESTART,
		ST_ADDR_RD,
		ST_DATA_RD,
		ST_MNACK,
		ST_STOP
	} i2c_state_e;

	typedef enum logic [1:0] {
		OWN_NONE,
		OWN_POLL,
		OWN_UART
	} bus_owner_e;

	// segment patterns, active low, dp off
	localparam logic [7:0] SEG_BLANK = 8'hff;
	localparam logic [9:0][7:0] SEG_DIGIT = {
		8'h90, 8'h80, 8'hf8, 8'h82, 8'h92,
		8'h99, 8'hb0, 8'ha4, 8'hf9, 8'hc0
	};

	// byte sent back to the host on a nack
	localparam logic [7:0] NACK_REPLY = 8'hff;

endpackage

`default_nettype wire

/* hw/seg_display.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shows an 8-bit reading in decimal on eight
// scanned digits, digit 0 on seg_choice bit 0
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module seg_display #(
	parameter int SCAN_CYCLES = 50_000
) (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic [7:0] reading,
	output logic [7:0] seg_number,
	output logic [7:0] seg_choice
);

	localparam int         CNT_W     = (SCAN_CYCLES > 1) ? $clog2(SCAN_CYCLES) : 1;
	localparam logic [3:0] BLANK_IDX = 4'd10;

	logic [3:0]       dig_ones;
	logic [3:0]       dig_tens;
	logic [3:0]       dig_huns;
	logic [CNT_W-1:0] scan_cnt;
	logic [2:0]       scan_pos;
	logic [2:0]       next_pos;
	logic [3:0]       next_idx;

	function automatic logic [7:0] seg_code(input logic [3:0] idx);
		if (idx < 4'd10) begin
			return panel_pkg::SEG_DIGIT[idx];
		end
		return panel_pkg::SEG_BLANK;
	endfunction

	// decimal digits, leading zeros blanked
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			dig_ones <= 4'd0;
			dig_tens <= BLANK_IDX;
			dig_huns <= BLANK_IDX;
		end else begin
			dig_ones <= 4'(reading % 8'd10);
			dig_tens <= (reading >= 8'd10) ? 4'((reading / 8'd10) % 8'd10) : BLANK_IDX;
			dig_huns <= (reading >= 8'd100) ? 4'(reading / 8'd100) : BLANK_IDX;
		end
	end

	assign next_pos = scan_pos + 3'd1;

	always_comb begin
		case (next_pos)
			3'd0:    next_idx = dig_ones;
			3'd1:    next_idx = dig_tens;
			3'd2:    next_idx = dig_huns;
			default: next_idx = BLANK_IDX;
		endcase
	end

	// first step lights digit 0
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			scan_cnt   <= '0;
			scan_pos   <= 3'd7;
			seg_choice <= 8'hff;
			seg_number <= panel_pkg::SEG_BLANK;
		end else if (scan_cnt == CNT_W'(SCAN_CYCLES - 1)) begin
			scan_cnt   <= '0;
			scan_pos   <= next_pos;
			seg_choice <= ~(8'b1 << next_pos);
			seg_number <= seg_code(next_idx);
		end else begin
			scan_cnt <= scan_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* hw/sensor_panel_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sensor panel top: poller and UART link share one
// I2C master through the arbiter, reading on display
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module sensor_panel_top #(
	parameter int         CLK_HZ      = 50_000_000,
	parameter int         BAUD_RATE   = 115_200,
	parameter int         I2C_HZ      = 100_000,
	parameter logic [6:0] DEVICE_ID   = 7'h54,
	parameter int         POLL_CYCLES = 5_000_000,
	parameter int         SCAN_CYCLES = 50_000
) (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       uart_rx,
	output logic       uart_tx,
	output logic       scl,
	inout  wire        sda,
	output logic [7:0] seg_number,
	output logic [7:0] seg_choice
);

	logic                poll_req;
	panel_pkg::i2c_req_t poll_cmd;
	logic                poll_done;
	logic                uart_req;
	panel_pkg::i2c_req_t uart_cmd;
	logic                uart_done;
	panel_pkg::i2c_rsp_t mst_rsp;
	panel_pkg::i2c_rsp_t arb_rsp;
	logic                mst_start;
	panel_pkg::i2c_req_t mst_cmd;
	logic                mst_done;
	logic [7:0]          reading;

	adc_poller #(
		.POLL_CYCLES (POLL_CYCLES)
	) i_adc_poller (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.req       (poll_req),
		.cmd       (poll_cmd),
		.done      (poll_done),
		.rsp       (arb_rsp),
		.reading   (reading)
	);

	uart_link #(
		.CLK_HZ    (CLK_HZ),
		.BAUD_RATE (BAUD_RATE)
	) i_uart_link (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.uart_rx   (uart_rx),
		.uart_tx   (uart_tx),
		.req       (uart_req),
		.cmd       (uart_cmd),
		.done      (uart_done),
		.rsp       (arb_rsp)
	);

	i2c_arbiter i_i2c_arbiter (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.poll_req  (poll_req),
		.poll_cmd  (poll_cmd),
		.poll_done (poll_done),
		.uart_req  (uart_req),
		.uart_cmd  (uart_cmd),
		.uart_done (uart_done),
		.rsp_in    (mst_rsp),
		.rsp       (arb_rsp),
		.mst_start (mst_start),
		.mst_cmd   (mst_cmd),
		.mst_done  (mst_done)
	);

	i2c_read_master #(
		.CLK_HZ    (CLK_HZ),
		.I2C_HZ    (I2C_HZ),
		.DEVICE_ID (DEVICE_ID)
	) i_i2c_read_master (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.start     (mst_start),
		.req       (mst_cmd),
		.done      (mst_done),
		.rsp       (mst_rsp),
		.scl       (scl),
		.sda       (sda)
	);

	seg_display #(
		.SCAN_CYCLES (SCAN_CYCLES)
	) i_seg_display (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.reading    (reading),
		.seg_number (seg_number),
		.seg_choice (seg_choice)
	);

endmodule

`default_nettype wire

/* hw/uart_link.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 8N1 host link: each received byte is a register
// address, the byte read back is sent as the reply
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module uart_link #(
	parameter int CLK_HZ    = 50_000_000,
	parameter int BAUD_RATE = 115_200
) (
	input  logic                sys_clk,
	input  logic                sys_rst_n,
	input  logic                uart_rx,
	output logic                uart_tx,
	output logic                req,
	output panel_pkg::i2c_req_t cmd,
	input  logic                done,
	input  panel_pkg::i2c_rsp_t rsp
);

	localparam int BIT_CYCLES  = CLK_HZ / BAUD_RATE;
	localparam int HALF_CYCLES = BIT_CYCLES / 2;
	localparam int CNT_W       = $clog2(BIT_CYCLES + 1);

	typedef enum logic [1:0] {
		S_IDLE,
		S_START,
		S_DATA,
		S_STOP
	} ser_state_e;

	logic [1:0]       rx_sync;
	logic             rx_s;
	ser_state_e       rx_state;
	logic [CNT_W-1:0] rx_cnt;
	logic [2:0]       rx_bit;
	logic [7:0]       rx_byte;
	logic             rx_valid;
	ser_state_e       tx_state;
	logic [CNT_W-1:0] tx_cnt;
	logic [2:0]       tx_bit;
	logic [7:0]       tx_byte;
	logic             busy;

	assign rx_s = rx_sync[1];
	// a read or reply in progress blocks new bytes
	assign busy = req || (tx_state != S_IDLE);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_sync  <= 2'b11;
			rx_state <= S_IDLE;
			rx_cnt   <= '0;
			rx_bit   <= '0;
			rx_byte  <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_sync  <= {rx_sync[0], uart_rx};
			rx_valid <= 1'b0;
			case (rx_state)
				S_IDLE: begin
					rx_cnt <= '0;
					if (!rx_s) begin
						rx_state <= S_START;
					end
				end
				S_START: begin
					// recheck at mid start bit, glitches go back to idle
					if (rx_cnt == CNT_W'(HALF_CYCLES - 1)) begin
						rx_cnt   <= '0;
						rx_bit   <= '0;
						rx_state <= rx_s ? S_IDLE : S_DATA;
					end else begin
						rx_cnt <= rx_cnt + 1'b1;
					end
				end
				S_DATA: begin
					if (rx_cnt == CNT_W'(BIT_CYCLES - 1)) begin
						rx_cnt  <= '0;
						rx_byte <= {rx_s, rx_byte[7:1]};
						rx_bit  <= rx_bit + 3'd1;
						if (rx_bit == 3'd7) begin
							rx_state <= S_STOP;
						end
					end else begin
						rx_cnt <= rx_cnt + 1'b1;
					end
				end
				S_STOP: begin
					if (rx_cnt == CNT_W'(BIT_CYCLES - 1)) begin
						// bad stop bit drops the byte
						rx_valid <= rx_s;
						rx_state <= S_IDLE;
					end else begin
						rx_cnt <= rx_cnt + 1'b1;
					end
				end
				default: rx_state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			req      <= 1'b0;
			cmd      <= '0;
			tx_state <= S_IDLE;
			tx_cnt   <= '0;
			tx_bit   <= '0;
			tx_byte  <= '0;
			uart_tx  <= 1'b1;
		end else begin
			if (rx_valid && !busy) begin
				req          <= 1'b1;
				cmd.reg_addr <= rx_byte;
			end
			case (tx_state)
				S_IDLE: uart_tx <= 1'b1;
				S_START: begin
					uart_tx <= 1'b0;
					if (tx_cnt == CNT_W'(BIT_CYCLES - 1)) begin
						tx_cnt   <= '0;
						tx_bit   <= '0;
						tx_state <= S_DATA;
					end else begin
						tx_cnt <= tx_cnt + 1'b1;
					end
				end
				S_DATA: begin
					uart_tx <= tx_byte[tx_bit];
					if (tx_cnt == CNT_W'(BIT_CYCLES - 1)) begin
						tx_cnt <= '0;
						tx_bit <= tx_bit + 3'd1;
						if (tx_bit == 3'd7) begin
							tx_state <= S_STOP;
						end
					end else begin
						tx_cnt <= tx_cnt + 1'b1;
					end
				end
				S_STOP: begin
					uart_tx <= 1'b1;
					if (tx_cnt == CNT_W'(BIT_CYCLES - 1)) begin
						tx_cnt   <= '0;
						tx_state <= S_IDLE;
					end else begin
						tx_cnt <= tx_cnt + 1'b1;
					end
				end
				default: tx_state <= S_IDLE;
			endcase
			// read finished, start the reply
			if (done) begin
				req      <= 1'b0;
				tx_byte  <= rsp.nack ? panel_pkg::NACK_REPLY : rsp.data;
				tx_cnt   <= '0;
				tx_state <= S_START;
			end
		end
	end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the sensor panel testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module tb_sensor_panel -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "Verification passed"; then
	exit 0
fi
exit 1

/* tb/i2c_adc_model.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// behavioral I2C ADC with 16 byte registers
// sampled on sys_clk, register file loaded by the testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module i2c_adc_model #(
	parameter logic [6:0] DEVICE_ID = 7'h48
) (
	input  wire              sys_clk,
	input  wire              sys_rst_n,
	input  wire              scl,
	inout  wire              sda,
	input  logic             wr_en,
	input  logic [3:0]       wr_addr,
	input  logic [7:0]       wr_data,
	output logic [15:0][7:0] regs
);

	typedef enum logic [1:0] {
		M_IDLE,
		M_ADDR,
		M_REG,
		M_SEND
	} slave_mode_e;

	slave_mode_e mode;
	logic        scl_q;
	logic        sda_q;
	logic [3:0]  nbits;
	logic [7:0]  shift;
	logic        read_dir;
	logic [3:0]  reg_ptr;
	logic [7:0]  tx_byte;
	logic        sda_low;

	// open drain, the testbench holds the pull-up
	assign sda = sda_low ? 1'b0 : 1'bz;

	always_ff @(posedge sys_clk) begin
		if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			mode     <= M_IDLE;
			scl_q    <= 1'b1;
			sda_q    <= 1'b1;
			nbits    <= '0;
			shift    <= '0;
			read_dir <= 1'b0;
			reg_ptr  <= '0;
			tx_byte  <= '0;
			sda_low  <= 1'b0;
		end else begin
			scl_q <= scl;
			sda_q <= sda;
			if (scl && scl_q && sda_q && !sda) begin
				// start or repeated start
				mode    <= M_ADDR;
				nbits   <= '0;
				sda_low <= 1'b0;
			end else if (scl && scl_q && !sda_q && sda) begin
				mode    <= M_IDLE;
				sda_low <= 1'b0;
			end else if (scl && !scl_q) begin
				shift <= {shift[6:0], sda};
				nbits <= nbits + 4'd1;
			end else if (!scl && scl_q) begin
				// sda only changes while scl is low
				case (mode)
					M_ADDR: begin
						if (nbits == 4'd8) begin
							if (shift[7:1] == DEVICE_ID) begin
								sda_low  <= 1'b1;
								read_dir <= shift[0];
							end else begin
								mode <= M_IDLE;
							end
						end else if (nbits == 4'd9) begin
							nbits <= '0;
							if (read_dir) begin
								mode    <= M_SEND;
								tx_byte <= regs[reg_ptr];
								sda_low <= !regs[reg_ptr][7];
							end else begin
								mode    <= M_REG;
								sda_low <= 1'b0;
							end
						end
					end
					M_REG: begin
						if (nbits == 4'd8) begin
							if (shift < 8'd16) begin
								sda_low <= 1'b1;
								reg_ptr <= shift[3:0];
							end else begin
								mode <= M_IDLE;
							end
						end else if (nbits == 4'd9) begin
							// wait here for the repeated start
							nbits   <= '0;
							sda_low <= 1'b0;
							mode    <= M_IDLE;
						end
					end
					M_SEND: begin
						if (nbits == 4'd8) begin
							sda_low <= 1'b0;
							mode    <= M_IDLE;
						end else if (nbits != 4'd0) begin
							sda_low <= !tx_byte[6];
							tx_byte <= {tx_byte[6:0], 1'b0};
						end
					end
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* tb/panel_checker.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// watches the panel outputs, decodes display and replies
// and compares them with the ADC model registers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module panel_checker #(
	parameter int BIT_CYCLES     = 16,
	parameter int TIMEOUT_CYCLES = 20_000
) (
	input  wire              sys_clk,
	input  wire              sys_rst_n,
	input  wire              uart_tx,
	input  wire              scl,
	input  wire              sda,
	input  logic [7:0]       seg_number,
	input  logic [7:0]       seg_choice,
	input  logic [15:0][7:0] model_regs,
	output int               test_count,
	output int               error_count
);

	localparam logic [3:0] BLANK = 4'd10;
	localparam logic [3:0] BAD   = 4'd15;

	logic [3:0] shown [8];
	int         disp_value  = -1;
	int         frame_count = 0;
	logic [7:0] replies [$];
	int         tests_run   = 0;
	int         errors_seen = 0;

	assign test_count  = tests_run;
	assign error_count = errors_seen;

	// active low segments, dp off
	function automatic logic [3:0] seg_digit(input logic [7:0] pattern);
		case (pattern)
			8'hc0:   return 4'd0;
			8'hf9:   return 4'd1;
			8'ha4:   return 4'd2;
			8'hb0:   return 4'd3;
			8'h99:   return 4'd4;
			8'h92:   return 4'd5;
			8'h82:   return 4'd6;
			8'hf8:   return 4'd7;
			8'h80:   return 4'd8;
			8'h90:   return 4'd9;
			8'hff:   return BLANK;
			default: return BAD;
		endcase
	endfunction

	// -1 for anything not shaped like a blanked decimal number
	function automatic int frame_value();
		for (int i = 3; i < 8; i++) begin
			if (shown[i] != BLANK) begin
				return -1;
			end
		end
		if (shown[0] > 4'd9) begin
			return -1;
		end
		if (shown[2] == BLANK) begin
			if (shown[1] == BLANK) begin
				return int'(shown[0]);
			end
			if (shown[1] == 4'd0 || shown[1] > 4'd9) begin
				return -1;
			end
			return int'(shown[1]) * 10 + int'(shown[0]);
		end
		if (shown[2] == 4'd0 || shown[2] > 4'd9 || shown[1] > 4'd9) begin
			return -1;
		end
		return int'(shown[2]) * 100 + int'(shown[1]) * 10 + int'(shown[0]);
	endfunction

	always @(posedge sys_clk) begin : display_monitor
		logic [2:0] pos;
		bit         lit;
		lit = 1'b0;
		pos = '0;
		for (int i = 0; i < 8; i++) begin
			if (seg_choice == 8'(~(8'h01 << i))) begin
				lit = 1'b1;
				pos = 3'(i);
			end
		end
		if (sys_rst_n && lit) begin
			shown[pos] = seg_digit(seg_number);
			// digit 7 closes a scan
			if (pos == 3'd7) begin
				disp_value = frame_value();
				frame_count++;
			end
		end
	end

	always begin : reply_decoder
		logic [7:0] bits;
		@(posedge sys_clk);
		if (sys_rst_n && !uart_tx) begin
			repeat (BIT_CYCLES / 2) @(posedge sys_clk);
			for (int i = 0; i < 8; i++) begin
				repeat (BIT_CYCLES) @(posedge sys_clk);
				bits[i] = uart_tx;
			end
			repeat (BIT_CYCLES) @(posedge sys_clk);
			if (!uart_tx) begin
				errors_seen++;
				$display("FAILED   reply byte 0x%02h had no stop bit", bits);
			end
			replies.push_back(bits);
		end
	end

	task automatic record_result(input string name, input bit ok, input string expected,
		input string actual);
		tests_run++;
		if (ok) begin
			$display("PASS     %s", name);
		end else begin
			errors_seen++;
			$display("MISMATCH %s expected %s actual %s", name, expected, actual);
		end
	endtask

	task automatic note_failure(input string text);
		tests_run++;
		errors_seen++;
		$display("FAILED   %s", text);
	endtask

	// uart_tx, scl, sda idle high and every digit off
	task automatic check_reset_state(input string name);
		logic [10:0] actual;
		@(negedge sys_clk);
		actual = {uart_tx, scl, sda, seg_choice};
		record_result(name, actual == 11'h7ff, "0x7ff", $sformatf("0x%03h", actual));
	endtask

	task automatic expect_reply(input string name, input logic [7:0] addr);
		logic [7:0] expected;
		logic [7:0] actual;
		int         waited;
		waited = 0;
		while (replies.size() == 0 && waited < TIMEOUT_CYCLES) begin
			@(negedge sys_clk);
			waited++;
		end
		if (replies.size() == 0) begin
			note_failure($sformatf("%s: no UART reply within %0d cycles", name, TIMEOUT_CYCLES));
		end else begin
			actual   = replies.pop_front();
			expected = (addr < 8'd16) ? model_regs[addr[3:0]] : 8'hff;
			record_result(name, actual == expected, $sformatf("0x%02h", expected),
				$sformatf("0x%02h", actual));
		end
	endtask

	// settle waits for a matching scan, otherwise the next scan is judged
	task automatic expect_display(input string name, input bit settle);
		int expected;
		int actual;
		int seen;
		int waited;
		bit got;
		bit finished;
		expected = -1;
		actual   = -1;
		seen     = frame_count;
		waited   = 0;
		got      = 1'b0;
		finished = 1'b0;
		while (!finished && waited < TIMEOUT_CYCLES) begin
			@(negedge sys_clk);
			waited++;
			if (frame_count != seen) begin
				seen     = frame_count;
				got      = 1'b1;
				actual   = disp_value;
				expected = int'(model_regs[0]);
				finished = !settle || (actual == expected);
			end
		end
		if (!got) begin
			note_failure($sformatf("%s: display never completed a scan", name));
		end else begin
			record_result(name, actual == expected, $sformatf("%0d", expected),
				$sformatf("%0d", actual));
		end
	endtask

endmodule

`default_nettype wire

/* tb/tb_sensor_panel.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the sensor panel with a modeled ADC,
// a UART host driver and a separate checker
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_sensor_panel;

	localparam int         CLK_HZ         = 1_000_000;
	localparam int         BAUD_RATE      = 62_500;
	localparam int         I2C_HZ         = 62_500;
	localparam logic [6:0] DEVICE_ID      = 7'h48;
	localparam int         POLL_CYCLES    = 3_000;
	localparam int         SCAN_CYCLES    = 4;
	localparam int         BIT_CYCLES     = CLK_HZ / BAUD_RATE;
	localparam int         TIMEOUT_CYCLES = 20_000;

	logic             sys_clk;
	logic             sys_rst_n;
	logic             uart_rx;
	logic             uart_tx;
	logic             scl;
	wire              sda;
	logic [7:0]       seg_number;
	logic [7:0]       seg_choice;
	logic             wr_en;
	logic [3:0]       wr_addr;
	logic [7:0]       wr_data;
	logic [15:0][7:0] model_regs;
	int               test_count;
	int               error_count;

	pullup (sda);

	always #10 sys_clk = ~sys_clk;

	sensor_panel_top #(
		.CLK_HZ      (CLK_HZ),
		.BAUD_RATE   (BAUD_RATE),
		.I2C_HZ      (I2C_HZ),
		.DEVICE_ID   (DEVICE_ID),
		.POLL_CYCLES (POLL_CYCLES),
		.SCAN_CYCLES (SCAN_CYCLES)
	) i_sensor_panel_top (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.uart_rx    (uart_rx),
		.uart_tx    (uart_tx),
		.scl        (scl),
		.sda        (sda),
		.seg_number (seg_number),
		.seg_choice (seg_choice)
	);

	i2c_adc_model #(
		.DEVICE_ID (DEVICE_ID)
	) i_i2c_adc_model (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.scl       (scl),
		.sda       (sda),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.regs      (model_regs)
	);

	panel_checker #(
		.BIT_CYCLES     (BIT_CYCLES),
		.TIMEOUT_CYCLES (TIMEOUT_CYCLES)
	) i_panel_checker (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.uart_tx     (uart_tx),
		.scl         (scl),
		.sda         (sda),
		.seg_number  (seg_number),
		.seg_choice  (seg_choice),
		.model_regs  (model_regs),
		.test_count  (test_count),
		.error_count (error_count)
	);

	task automatic write_reg(input logic [3:0] addr, input logic [7:0] value);
		@(posedge sys_clk);
		wr_en   <= 1'b1;
		wr_addr <= addr;
		wr_data <= value;
		@(posedge sys_clk);
		wr_en   <= 1'b0;
	endtask

	// 8N1, LSB first
	task automatic send_byte(input logic [7:0] value);
		logic [9:0] frame;
		frame = {1'b1, value, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge sys_clk);
			uart_rx <= frame[i];
			repeat (BIT_CYCLES - 1) @(posedge sys_clk);
		end
	endtask

	// a quiet bus followed by scl going low marks a new transaction
	task automatic wait_poll_start(output bit found);
		int waited;
		int idle;
		waited = 0;
		idle   = 0;
		found  = 1'b0;
		while (!found && waited < TIMEOUT_CYCLES) begin
			@(negedge sys_clk);
			waited++;
			if (scl) begin
				idle++;
			end else begin
				found = (idle >= 32);
				idle  = 0;
			end
		end
	endtask

	initial begin
		logic [7:0] addr;
		bit         found;
		sys_clk   = 1'b0;
		sys_rst_n = 1'b0;
		uart_rx   = 1'b1;
		wr_en     = 1'b0;
		wr_addr   = '0;
		wr_data   = '0;
		void'($urandom(32'hdffd));
		repeat (4) @(posedge sys_clk);
		sys_rst_n <= 1'b1;
		i_panel_checker.check_reset_state("reset_state");

		for (int i = 0; i < 16; i++) begin
			write_reg(4'(i), 8'($urandom));
		end

		for (int t = 0; t < 4; t++) begin
			write_reg(4'd0, 8'($urandom));
			i_panel_checker.expect_display($sformatf("poll_display_%0d", t), 1'b1);
		end

		for (int t = 0; t < 6; t++) begin
			addr = 8'($urandom_range(15, 0));
			send_byte(addr);
			i_panel_checker.expect_reply($sformatf("uart_read_%0d_addr_%0d", t, addr), addr);
		end

		// register byte out of range, device nacks it
		addr = 8'($urandom_range(255, 16));
		send_byte(addr);
		i_panel_checker.expect_reply($sformatf("nack_reply_addr_%0d", addr), addr);
		i_panel_checker.expect_display("nack_display_kept", 1'b0);

		// host byte lands while the poller owns the bus
		write_reg(4'd0, 8'($urandom));
		wait_poll_start(found);
		if (!found) begin
			i_panel_checker.note_failure("sharing: no poll transaction seen on the I2C bus");
		end
		addr = 8'($urandom_range(15, 0));
		send_byte(addr);
		i_panel_checker.expect_reply($sformatf("shared_read_addr_%0d", addr), addr);
		i_panel_checker.expect_display("shared_display", 1'b1);

		$display("tests run: %0d, errors: %0d", test_count, error_count);
		if (error_count == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
